/* list.f */
+incdir+verilog
verilog/dmem_pkg.sv
verilog/dmem_bram.sv
verilog/dcache.sv
verilog/scratchpad.sv
verilog/dmem_port.sv
verilog/dmem_top.sv
bench/bus_memory_model.sv
bench/tb_dmem.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_dmem
FILELIST  = list.f
BUILD     = obj_dir
LOG       = sim.log
FAIL_TEXT = === FAIL ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and fail on a reported failure"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/tb_dmem.sv */
// Testbench for the data-memory port.
// Runs a table of loads, stores, uncached reads and flushes against a
// bus memory model and checks every load and the scratchpad bus silence.
`default_nettype none
`timescale 1ns/1ps
`include "dmem_params.svh"

module tb_dmem
	import dmem_pkg::*;
();

	localparam int PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int LINES = 1 << `DMEM_INDEX_BITS;
	localparam int BUS_DELAY = 6;
	localparam int WORST_CYCLES = LINES * (4 + BUS_DELAY);
	localparam int MARGIN = 20;
	localparam int RANDOM_ROWS = 40;
	localparam int WINDOW_BITS = $clog2(`DMEM_SCRATCH_WORDS) + 2;
	localparam logic [31:0] SCRATCH_BASE = `DMEM_SCRATCH_BASE;
	localparam logic [31:0] UNCACHED = 32'h1 << `DMEM_UNCACHED_BIT;

	// Small address set for the random mix, with shared indexes.
	localparam logic [31:0] SLOT_ADDRESS [8] = '{
		32'h0000_0800, 32'h0000_0900, 32'h0000_0A00, 32'h0000_0804,
		32'h0000_0904, 32'h0000_0C08, 32'h0000_0D0C, 32'h0000_0810
	};

	typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_UNCACHED_READ, OP_FLUSH} op_t;

	typedef struct packed {
		op_t         op;
		logic [31:0] address;
		logic [31:0] wdata;
		logic [31:0] expected;
	} row_t;

	logic        clock;
	logic        reset;
	logic        request;
	dmem_req_t   req;
	logic        ready;
	logic [31:0] rdata;
	logic        bus_request;
	bus_req_t    bus;
	logic        bus_ready;
	logic [31:0] bus_rdata;
	logic [31:0] bus_count;

	row_t        rows[$];
	string       names[$];
	logic [31:0] slot_value [8];
	int          passed;
	int          failed;
	bit          table_ready;

	dmem_top u_dmem_top (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_req(req),
		.o_ready(ready),
		.o_rdata(rdata),
		.o_bus_request(bus_request),
		.o_bus(bus),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	bus_memory_model u_bus_memory_model (
		.i_clock(clock),
		.i_reset(reset),
		.i_bus_request(bus_request),
		.i_bus(bus),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata),
		.o_request_count(bus_count)
	);

	initial clock = 1'b0;
	always #(PERIOD / 2) clock = ~clock;

	// ========================================
	// Table
	// ========================================
	function automatic logic [31:0] preload_word(input logic [31:0] address);
		return 32'hDA7A_0000 | {18'b0, address[13:2], 2'b00};
	endfunction

	function automatic logic in_scratch(input logic [31:0] address);
		return address[31:WINDOW_BITS] == SCRATCH_BASE[31:WINDOW_BITS];
	endfunction

	task automatic add_row(input string name, input op_t op, input logic [31:0] address,
		input logic [31:0] wdata, input logic [31:0] expected);
		row_t row;
		row = '{op: op, address: address, wdata: wdata, expected: expected};
		rows.push_back(row);
		names.push_back(name);
	endtask

	// Expected loads follow the word-array model of the slots.
	task automatic add_random_rows();
		logic [31:0] data;
		int slot;
		for (int i = 0; i < 8; i++)
			slot_value[i] = preload_word(SLOT_ADDRESS[i]);
		for (int i = 0; i < RANDOM_ROWS; i++) begin
			slot = int'($urandom % 8);
			if ($urandom % 2 == 0) begin
				data = $urandom;
				slot_value[slot] = data;
				add_row($sformatf("rand_write_%0d", i), OP_WRITE, SLOT_ADDRESS[slot],
					data, 32'h0);
			end else begin
				add_row($sformatf("rand_read_%0d", i), OP_READ, SLOT_ADDRESS[slot],
					32'h0, slot_value[slot]);
			end
		end
	endtask

	task automatic build_table();
		// Clean miss and refill.
		add_row("read_cold", OP_READ, 32'h0000_0040, 32'h0, 32'hDA7A_0040);
		// Store stays in the cache, memory keeps the old word.
		add_row("write_a", OP_WRITE, 32'h0000_0080, 32'h1111_AAAA, 32'h0);
		add_row("read_a", OP_READ, 32'h0000_0080, 32'h0, 32'h1111_AAAA);
		add_row("uncached_a_old", OP_UNCACHED_READ, 32'h0000_0080, 32'h0, 32'hDA7A_0080);
		// Same index, the dirty line goes out first.
		add_row("write_b_evict", OP_WRITE, 32'h0000_0180, 32'h2222_BBBB, 32'h0);
		add_row("uncached_a_new", OP_UNCACHED_READ, 32'h0000_0080, 32'h0, 32'h1111_AAAA);
		add_row("read_a_refill", OP_READ, 32'h0000_0080, 32'h0, 32'h1111_AAAA);
		add_row("uncached_b", OP_UNCACHED_READ, 32'h0000_0180, 32'h0, 32'h2222_BBBB);
		// Several dirty lines, then a flush.
		add_row("write_f0", OP_WRITE, 32'h0000_0200, 32'h3333_0001, 32'h0);
		add_row("write_f1", OP_WRITE, 32'h0000_0204, 32'h3333_0002, 32'h0);
		add_row("write_f2", OP_WRITE, 32'h0000_0308, 32'h3333_0003, 32'h0);
		add_row("write_f3", OP_WRITE, 32'h0000_0040, 32'h3333_0004, 32'h0);
		add_row("uncached_pre_flush", OP_UNCACHED_READ, 32'h0000_0200, 32'h0, 32'hDA7A_0200);
		add_row("flush", OP_FLUSH, 32'h0000_0000, 32'h0, 32'h0);
		add_row("uncached_f0", OP_UNCACHED_READ, 32'h0000_0200, 32'h0, 32'h3333_0001);
		add_row("uncached_f1", OP_UNCACHED_READ, 32'h0000_0204, 32'h0, 32'h3333_0002);
		add_row("uncached_f2", OP_UNCACHED_READ, 32'h0000_0308, 32'h0, 32'h3333_0003);
		add_row("uncached_f3", OP_UNCACHED_READ, 32'h0000_0040, 32'h0, 32'h3333_0004);
		// Dirty lines on the scratchpad indexes, a cache access there would evict.
		add_row("write_index_lo", OP_WRITE, 32'h0000_0010, 32'h4444_0010, 32'h0);
		add_row("write_index_hi", OP_WRITE, 32'h0000_00FC, 32'h4444_00FC, 32'h0);
		// Scratchpad round trips.
		add_row("scratch_write_lo", OP_WRITE, 32'h0001_0010, 32'h5C5C_0001, 32'h0);
		add_row("scratch_read_lo", OP_READ, 32'h0001_0010, 32'h0, 32'h5C5C_0001);
		add_row("scratch_write_hi", OP_WRITE, 32'h0001_03FC, 32'h5C5C_03FC, 32'h0);
		add_row("scratch_read_hi", OP_READ, 32'h0001_03FC, 32'h0, 32'h5C5C_03FC);
		add_random_rows();
	endtask

	// ========================================
	// Apply and check
	// ========================================
	task automatic check_row(input int index, input logic [31:0] got,
		input logic [31:0] bus_used);
		row_t row;
		logic ok;
		row = rows[index];
		ok = 1'b1;
		if ((row.op == OP_READ || row.op == OP_UNCACHED_READ) && got !== row.expected) begin
			$display("FAIL %s expected %h actual %h", names[index], row.expected, got);
			ok = 1'b0;
		end
		if (in_scratch(row.address) && bus_used != 0) begin
			$display("FAIL %s expected 0 bus requests actual %0d", names[index], bus_used);
			ok = 1'b0;
		end
		if (ok) begin
			passed++;
			$display("PASS %s", names[index]);
		end else begin
			failed++;
		end
	endtask

	task automatic run_row(input int index);
		row_t row;
		dmem_req_t next;
		logic [31:0] count_before;
		logic [31:0] count_after;
		logic [31:0] got;
		row = rows[index];
		next.rw = (row.op == OP_WRITE);
		next.flush = (row.op == OP_FLUSH);
		next.address = (row.op == OP_UNCACHED_READ) ? (row.address | UNCACHED) : row.address;
		next.wdata = row.wdata;
		@(negedge clock);
		count_before = bus_count;
		@(posedge clock);
		request <= 1'b1;
		req <= next;
		// Sampled mid-cycle, away from the edge that moves it.
		do @(negedge clock); while (!ready);
		got = rdata;
		count_after = bus_count;
		@(posedge clock);
		request <= 1'b0;
		check_row(index, got, count_after - count_before);
	endtask

	initial begin : watchdog
		int limit;
		wait (table_ready);
		limit = RESET_CYCLES + LINES + 2 + rows.size() * (WORST_CYCLES + BUS_DELAY + MARGIN);
		repeat (limit) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		void'($urandom(32'h695b));
		reset = 1'b1;
		request = 1'b0;
		req = '0;
		passed = 0;
		failed = 0;
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		foreach (rows[i])
			run_row(i);
		$display("%0d passed, %0d failed out of %0d", passed, failed, rows.size());
		if (failed == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/bus_memory_model.sv */
// Bus slave for the testbench.
// Word memory with a preloaded pattern, a random response delay and a
// count of the transfers it has accepted.
`default_nettype none
`timescale 1ns/1ps

module bus_memory_model
	import dmem_pkg::*;
(
	input  wire           i_clock,
	input  wire           i_reset,
	input  wire           i_bus_request,
	input  wire bus_req_t i_bus,
	output logic          o_bus_ready,
	output logic [31:0]   o_bus_rdata,
	output logic [31:0]   o_request_count
);

	localparam int WORDS = 4096;

	logic [31:0] mem [WORDS];
	logic        busy;
	logic [1:0]  delay;
	logic [11:0] word_index;

	// High address bits are ignored, so an uncached address aliases its cached twin.
	assign word_index = i_bus.address[13:2];

	always @(posedge i_clock) begin
		if (i_reset) begin
			// Each word holds DA7A above its own byte address.
			for (int i = 0; i < WORDS; i++)
				mem[i] <= 32'hDA7A_0000 | (i << 2);
			busy <= 1'b0;
			delay <= 2'd0;
			o_bus_ready <= 1'b0;
			o_bus_rdata <= 32'h0;
			o_request_count <= 32'h0;
		end else begin
			o_bus_ready <= 1'b0;
			// The master drops its request on the edge that sees ready.
			if (!o_bus_ready) begin
				if (busy) begin
					if (delay == 2'd0) begin
						busy <= 1'b0;
						o_bus_ready <= 1'b1;
						o_bus_rdata <= mem[word_index];
						if (i_bus.rw)
							mem[word_index] <= i_bus.wdata;
					end else begin
						delay <= delay - 2'd1;
					end
				end else if (i_bus_request) begin
					busy <= 1'b1;
					delay <= 2'($urandom % 4);
					o_request_count <= o_request_count + 32'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/dmem_top.sv */
// Data-memory port top level.
// Router, write-back cache and scratchpad behind one request interface.
`default_nettype none
`timescale 1ns/1ps

module dmem_top
	import dmem_pkg::*;
(
	input  wire            i_clock,
	input  wire            i_reset,

	// Load/store unit.
	input  wire            i_request,
	input  wire dmem_req_t i_req,
	output logic           o_ready,
	output logic [31:0]    o_rdata,

	// External bus.
	output logic           o_bus_request,
	output bus_req_t       o_bus,
	input  wire            i_bus_ready,
	input  wire [31:0]     i_bus_rdata
);

	logic        cache_request;
	logic        cache_ready;
	logic [31:0] cache_rdata;
	logic        scratch_request;
	logic        scratch_ready;
	logic [31:0] scratch_rdata;

	dmem_port u_port (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_req(i_req),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_cache_request(cache_request),
		.o_scratch_request(scratch_request),
		.i_cache_ready(cache_ready),
		.i_cache_rdata(cache_rdata),
		.i_scratch_ready(scratch_ready),
		.i_scratch_rdata(scratch_rdata)
	);

	// Both sides see the request payload, only one sees the level.
	dcache u_dcache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(cache_request),
		.i_req(i_req),
		.o_ready(cache_ready),
		.o_rdata(cache_rdata),
		.o_bus_request(o_bus_request),
		.o_bus(o_bus),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	scratchpad u_scratchpad (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(scratch_request),
		.i_req(i_req),
		.o_ready(scratch_ready),
		.o_rdata(scratch_rdata)
	);

endmodule

`default_nettype wire

/* verilog/dmem_port.sv */
// Data-memory request router.
// Sends each request to the cache or the scratchpad by address and
// returns the response of the side that took it.
`default_nettype none
`timescale 1ns/1ps
`include "dmem_params.svh"

module dmem_port
	import dmem_pkg::*;
(
	input  wire            i_clock,
	input  wire            i_reset,

	// Requester side.
	input  wire            i_request,
	input  wire dmem_req_t i_req,
	output logic           o_ready,
	output logic [31:0]    o_rdata,

	// Targets.
	output logic           o_cache_request,
	output logic           o_scratch_request,
	input  wire            i_cache_ready,
	input  wire [31:0]     i_cache_rdata,
	input  wire            i_scratch_ready,
	input  wire [31:0]     i_scratch_rdata
);

	localparam int WINDOW_BITS = $clog2(`DMEM_SCRATCH_WORDS) + 2;
	localparam logic [31:0] SCRATCH_BASE = `DMEM_SCRATCH_BASE;

	logic in_window;
	logic busy;
	logic sel_scratch;
	logic to_scratch;

	// Flush is a cache operation whatever its address.
	assign in_window = !i_req.flush &&
		(i_req.address[31:WINDOW_BITS] == SCRATCH_BASE[31:WINDOW_BITS]);

	// Side is frozen once the request has been taken.
	assign to_scratch = busy ? sel_scratch : in_window;

	assign o_cache_request = i_request && !to_scratch;
	assign o_scratch_request = i_request && to_scratch;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			sel_scratch <= 1'b0;
		end else if (o_ready) begin
			busy <= 1'b0;
		end else if (i_request && !busy) begin
			busy <= 1'b1;
			sel_scratch <= in_window;
		end
	end

	// Response merge.
	assign o_ready = sel_scratch ? i_scratch_ready : i_cache_ready;
	assign o_rdata = sel_scratch ? i_scratch_rdata : i_cache_rdata;

	// Only one side ever holds a request, so only one may answer.
	a_single_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_cache_ready && i_scratch_ready));

endmodule

`default_nettype wire

/* verilog/scratchpad.sv */
// Tightly-coupled scratchpad RAM.
// Answers every request one cycle after it is sampled, never uses the bus.
`default_nettype none
`timescale 1ns/1ps
`include "dmem_params.svh"

module scratchpad
	import dmem_pkg::*;
(
	input  wire            i_clock,
	input  wire            i_reset,
	input  wire            i_request,
	input  wire dmem_req_t i_req,
	output logic           o_ready,
	output logic [31:0]    o_rdata
);

	localparam int WORDS = `DMEM_SCRATCH_WORDS;
	localparam int OFFSET_BITS = $clog2(WORDS);

	logic                   accept;
	logic [OFFSET_BITS-1:0] offset;

	// Held request during the ready cycle is not served again.
	assign accept = i_request && !o_ready;

	// Word offset inside the window.
	assign offset = i_req.address[OFFSET_BITS+1:2];

	dmem_bram #(
		.entry_t(logic [31:0]),
		.DEPTH(WORDS)
	) u_words (
		.i_clock(i_clock),
		.i_write(accept && i_req.rw),
		.i_address(offset),
		.i_wdata(i_req.wdata),
		.o_rdata(o_rdata)
	);

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_ready <= 1'b0;
		else
			o_ready <= accept;
	end

endmodule

`default_nettype wire

/* verilog/dcache.sv */
// Direct-mapped write-back data cache with one word per line.
// Clears all lines after reset, writes back dirty victims before a
// refill, passes uncached addresses to the bus and flushes on request.
`default_nettype none
`timescale 1ns/1ps
`include "dmem_params.svh"

module dcache
	import dmem_pkg::*;
(
	input  wire            i_clock,
	input  wire            i_reset,

	// Requester side.
	input  wire            i_request,
	input  wire dmem_req_t i_req,
	output logic           o_ready,
	output logic [31:0]    o_rdata,

	// Bus side.
	output logic           o_bus_request,
	output bus_req_t       o_bus,
	input  wire            i_bus_ready,
	input  wire [31:0]     i_bus_rdata
);

	localparam int INDEX_BITS = `DMEM_INDEX_BITS;
	localparam int LINES = 1 << INDEX_BITS;

	typedef enum logic [3:0] {
		INITIALIZE,
		IDLE,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE,
		FLUSH_NEXT
	} state_t;

	state_t                state;
	logic [INDEX_BITS:0]   sweep;
	logic                  sweep_state;
	logic [INDEX_BITS-1:0] ram_address;
	logic                  ram_write;
	cache_line_t           ram_wdata;
	cache_line_t           line;

	logic [29:0]           req_tag;
	logic [INDEX_BITS-1:0] req_index;
	logic                  cacheable;
	logic                  start;
	logic                  hot_hit;
	logic                  victim_dirty;

	cache_line_t           store_line;
	cache_line_t           refill_line;
	cache_line_t           clean_line;
	bus_req_t              victim_bus;
	bus_req_t              fill_bus;
	bus_req_t              pass_bus;

	// ========================================
	// Line storage
	// ========================================
	dmem_bram #(
		.entry_t(cache_line_t),
		.DEPTH(LINES)
	) u_lines (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(line)
	);

	assign req_tag = i_req.address[31:2];
	assign req_index = i_req.address[INDEX_BITS+1:2];
	assign cacheable = !i_req.address[`DMEM_UNCACHED_BIT];

	// The cycle with o_ready high still carries the old request.
	assign start = i_request && !o_ready;

	// Line output belongs to the address of the previous cycle.
	// The full-address tag makes a stale index miss safely.
	assign hot_hit = line.valid && (line.tag == req_tag);
	assign victim_dirty = line.valid && line.dirty && (line.tag != req_tag);

	assign sweep_state = state inside {INITIALIZE, FLUSH_SETUP, FLUSH_CHECK,
		FLUSH_WRITE, FLUSH_NEXT};
	assign ram_address = sweep_state ? sweep[INDEX_BITS-1:0] : req_index;

	assign store_line = '{data: i_req.wdata, tag: req_tag, dirty: 1'b1, valid: 1'b1};
	assign refill_line = '{data: i_bus_rdata, tag: req_tag, dirty: 1'b0, valid: 1'b1};
	assign clean_line = '{data: line.data, tag: line.tag, dirty: 1'b0, valid: 1'b1};

	assign victim_bus = '{rw: 1'b1, address: {line.tag, 2'b00}, wdata: line.data};
	assign fill_bus = '{rw: 1'b0, address: {req_tag, 2'b00}, wdata: 32'h0};
	assign pass_bus = '{rw: i_req.rw, address: i_req.address, wdata: i_req.wdata};

	// Line writes happen in the same cycle as the deciding state.
	always_comb begin
		ram_write = 1'b0;
		ram_wdata = store_line;
		case (state)
			INITIALIZE: begin
				ram_write = !sweep[INDEX_BITS];
				ram_wdata = '0;
			end
			IDLE: ram_write = start && !i_req.flush && cacheable && i_req.rw && hot_hit;
			WRITE_SETUP: ram_write = !victim_dirty;
			WRITE_WAIT: ram_write = i_bus_ready;
			READ_BUS_WAIT: begin
				ram_write = o_bus_request && i_bus_ready;
				ram_wdata = refill_line;
			end
			FLUSH_WRITE: begin
				ram_write = i_bus_ready;
				ram_wdata = clean_line;
			end
			default: ram_write = 1'b0;
		endcase
	end

	// ========================================
	// Controller
	// ========================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= INITIALIZE;
			sweep <= '0;
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				INITIALIZE: begin
					if (sweep[INDEX_BITS])
						state <= IDLE;
					else
						sweep <= sweep + 1'b1;
				end
				IDLE: begin
					if (start) begin
						if (i_req.flush) begin
							sweep <= '0;
							state <= FLUSH_SETUP;
						end else if (!cacheable) begin
							o_bus <= pass_bus;
							o_bus_request <= 1'b1;
							state <= PASS_THROUGH;
						end else if (hot_hit) begin
							o_rdata <= line.data;
							o_ready <= 1'b1;
						end else if (i_req.rw) begin
							state <= WRITE_SETUP;
						end else begin
							state <= READ_SETUP;
						end
					end
				end
				PASS_THROUGH: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_rdata <= i_bus_rdata;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end
				// Store, with write-back of a dirty victim first.
				WRITE_SETUP: begin
					if (victim_dirty) begin
						o_bus <= victim_bus;
						o_bus_request <= 1'b1;
						state <= WRITE_WAIT;
					end else begin
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end
				WRITE_WAIT: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end
				// Load, line output now matches the request index.
				READ_SETUP: begin
					if (hot_hit) begin
						o_rdata <= line.data;
						o_ready <= 1'b1;
						state <= IDLE;
					end else if (victim_dirty) begin
						o_bus <= victim_bus;
						o_bus_request <= 1'b1;
						state <= READ_WB_WAIT;
					end else begin
						o_bus <= fill_bus;
						o_bus_request <= 1'b1;
						state <= READ_BUS_WAIT;
					end
				end
				READ_WB_WAIT: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_bus <= fill_bus;
						state <= READ_BUS_WAIT;
					end
				end
				READ_BUS_WAIT: begin
					if (o_bus_request && i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_rdata <= i_bus_rdata;
						o_ready <= 1'b1;
						state <= IDLE;
					end else begin
						o_bus_request <= 1'b1;
					end
				end
				// Walk all lines, writing back the dirty ones.
				FLUSH_SETUP: begin
					if (sweep[INDEX_BITS]) begin
						o_ready <= 1'b1;
						state <= IDLE;
					end else begin
						state <= FLUSH_CHECK;
					end
				end
				FLUSH_CHECK: begin
					if (line.valid && line.dirty) begin
						o_bus <= victim_bus;
						o_bus_request <= 1'b1;
						state <= FLUSH_WRITE;
					end else begin
						sweep <= sweep + 1'b1;
						state <= FLUSH_SETUP;
					end
				end
				FLUSH_WRITE: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= FLUSH_NEXT;
					end
				end
				FLUSH_NEXT: begin
					sweep <= sweep + 1'b1;
					state <= FLUSH_SETUP;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ========================================
	// Checks
	// ========================================
	a_no_bus_in_init: assert property (@(posedge i_clock) disable iff (i_reset)
		state == INITIALIZE |-> !o_bus_request);

	a_bus_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus));

	a_ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |=> !o_ready);

endmodule

`default_nettype wire

/* verilog/dmem_bram.sv */
// Single-port block RAM with a registered read.
// Entry type is a parameter so one RAM serves lines and words.
`default_nettype none
`timescale 1ns/1ps

module dmem_bram #(
	parameter type entry_t = logic [31:0],
	parameter int DEPTH = 64,
	localparam int ADDR_BITS = $clog2(DEPTH)
)(
	input  wire                 i_clock,
	input  wire                 i_write,
	input  wire [ADDR_BITS-1:0] i_address,
	input  wire entry_t         i_wdata,
	output entry_t              o_rdata
);

	entry_t mem [DEPTH];

	// Write-first, a written entry shows up on the next cycle.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_address] <= i_wdata;
			o_rdata <= i_wdata;
		end else begin
			o_rdata <= mem[i_address];
		end
	end

	// A write to an unknown location would corrupt the whole array.
	a_write_address_known: assert property (
		@(posedge i_clock) i_write |-> !$isunknown(i_address)
	);

endmodule

`default_nettype wire

/* verilog/dmem_pkg.sv */
// Data-memory port types.
// Request, bus transfer and cache line layouts.
`default_nettype none

package dmem_pkg;

	// ========================================
	// Load/store unit request
	// ========================================
	typedef struct packed {
		logic        rw;
		logic        flush;
		logic [31:0] address;
		logic [31:0] wdata;
	} dmem_req_t;

	// ========================================
	// External bus transfer
	// ========================================
	typedef struct packed {
		logic        rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	// ========================================
	// Cache line
	// ========================================
	// Tag is the full word address, so a hit needs no index compare.
	typedef struct packed {
		logic [31:0] data;
		logic [29:0] tag;
		logic        dirty;
		logic        valid;
	} cache_line_t;

endpackage

`default_nettype wire

/* verilog/dmem_params.svh */
// Data-memory port parameters.
// Cache geometry, scratchpad window and the uncached address bit.

`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

// Cache index bits, 64 one-word lines.
`define DMEM_INDEX_BITS 6

// Scratchpad size in 32-bit words.
`define DMEM_SCRATCH_WORDS 256

// Base of the 1 KiB scratchpad window.
`define DMEM_SCRATCH_BASE 32'h0001_0000

// Address bit that selects an uncached access.
`define DMEM_UNCACHED_BIT 31

`endif
